// ==== logic/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data bus and register width
`define CPU_DATA_W 8

// address bus, IP and DP width
`define CPU_ADDR_W 16

`define CPU_RESET_IP 16'h0000 // IP and DP after reset, first fetch address

`endif

// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

    // alu operation, x is always A, y is the selected operand
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_ADC  = 4'd1,  // add with stored carry
        ALU_SUB  = 4'd2,
        ALU_SBC  = 4'd3,  // subtract with stored borrow
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_NOT  = 4'd7,  // of x
        ALU_SHL  = 4'd8,
        ALU_SHR  = 4'd9,
        ALU_ROL  = 4'd10, // through carry
        ALU_ROR  = 4'd11, // through carry
        ALU_MOV  = 4'd12, // result is y
        ALU_INC  = 4'd13,
        ALU_DEC  = 4'd14,
        ALU_PASS = 4'd15  // result is x
    } alu_op_e;

    // register index, the dd field of an instruction
    typedef enum logic [1:0] {
        REG_A  = 2'd0,
        REG_B  = 2'd1,
        REG_PL = 2'd2,
        REG_PH = 2'd3
    } reg_idx_e;

    // bit positions in the flag vector
    localparam int FLAG_Z = 0;
    localparam int FLAG_C = 1;
    localparam int FLAG_N = 2;
    localparam int FLAG_V = 3;

    // class prefixes of the non-alu instructions
    localparam logic [3:0] OP_LD  = 4'b1000; // ir[7:4]
    localparam logic [3:0] OP_LDI = 4'b1010; // ir[7:4]
    localparam logic [3:0] OP_ST  = 4'b1011; // ir[7:4]
    localparam logic [4:0] OP_JC  = 5'b11000; // ir[7:3]
    localparam logic [4:0] OP_JMP = 5'b11001; // ir[7:3]

    localparam logic [7:0] HALT_OPCODE = 8'hFF;

endpackage

// ==== logic/control_unit.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module control_unit (
    input  logic                   clk,
    input  logic                   n_rst,
    input  logic [`CPU_DATA_W-1:0] mem_rdata,  // opcode during fetch
    input  logic [3:0]             flags,      // stored alu flags
    output cpu_pkg::alu_op_e       alu_op,
    output cpu_pkg::reg_idx_e      reg_sel,
    output logic                   we_a,
    output logic                   we_b,
    output logic                   we_pl,
    output logic                   we_ph,
    output logic                   we_flags,
    output logic                   wb_from_mem,
    output logic                   st_src,     // 0 stores A, 1 stores B
    output logic                   addr_dp,    // 0 address from IP, 1 from DP
    output logic                   ip_inc,
    output logic                   swap_p,
    output logic                   mem_we,
    output logic                   mem_oe,
    output logic                   halted
);

    logic [`CPU_DATA_W-1:0] ir;    // instruction register
    logic                   phase; // 0 fetch, 1 execute

    // instruction classes
    logic is_alu;
    logic is_ld;
    logic is_ldi;
    logic is_st;
    logic is_jc;
    logic is_jmp;
    logic is_hlt;

    logic       fetch;      // live fetch cycle, never while halted
    logic       exec;
    logic [3:0] dst_onehot; // decoded dd field
    logic       wr_dst;     // instruction writes r[dd]
    logic       cond_ok;
    logic       take_jump;

    // ALU0 0oooo0dd, ALU1 0oooo1dd
    assign is_alu = ~ir[7];
    assign is_ld  = ir[7:4] == cpu_pkg::OP_LD;
    assign is_ldi = ir[7:4] == cpu_pkg::OP_LDI;
    assign is_st  = ir[7:4] == cpu_pkg::OP_ST;
    assign is_jc  = ir[7:3] == cpu_pkg::OP_JC;
    assign is_jmp = ir[7:3] == cpu_pkg::OP_JMP;
    assign is_hlt = ir == cpu_pkg::HALT_OPCODE; // 11111xxx otherwise is a nop

    assign fetch = ~phase & ~halted;
    assign exec  = phase;

    assign dst_onehot = 4'b0001 << ir[1:0];

    // ld, ldi and alu1 write r[dd], alu0 always writes A
    assign wr_dst = exec & (is_ld | is_ldi | (is_alu & ir[2]));

    assign we_a  = (wr_dst & dst_onehot[cpu_pkg::REG_A])
                 | (exec & is_alu & ~ir[2]);
    assign we_b  = wr_dst & dst_onehot[cpu_pkg::REG_B];
    assign we_pl = wr_dst & dst_onehot[cpu_pkg::REG_PL];
    assign we_ph = wr_dst & dst_onehot[cpu_pkg::REG_PH];

    assign we_flags = exec & is_alu; // every alu instruction updates flags

    assign alu_op      = cpu_pkg::alu_op_e'(ir[6:3]);
    assign reg_sel     = cpu_pkg::reg_idx_e'(ir[1:0]); // y operand, also dd
    assign wb_from_mem = is_ld | is_ldi;  // mux select only
    assign st_src      = ir[0];

    // Jc 11000iff, taken when flag[ff] differs from i
    assign cond_ok   = flags[ir[1:0]] ^ ir[2];
    assign take_jump = is_jmp | (is_jc & cond_ok);

    assign swap_p  = exec & take_jump;
    assign addr_dp = exec & (is_ld | is_st);
    assign ip_inc  = fetch | (exec & is_ldi); // ldi steps over its immediate
    assign mem_we  = exec & is_st;
    assign mem_oe  = fetch | (exec & (is_ld | is_ldi));

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            phase  <= 1'b0;
            ir     <= '0;
            halted <= 1'b0;
        end else if (!halted) begin
            phase <= ~phase;
            if (!phase) begin
                ir <= mem_rdata; // opcode at IP
            end
            if (phase && is_hlt) begin
                halted <= 1'b1; // sticky until reset, phase stays fetch
            end
        end
    end

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module alu (
    input  logic                   clk,
    input  logic                   n_rst,
    input  logic [`CPU_DATA_W-1:0] x,        // always A
    input  logic [`CPU_DATA_W-1:0] y,        // selected operand
    input  cpu_pkg::alu_op_e       op,
    input  logic                   we_flags,
    output logic [`CPU_DATA_W-1:0] result,
    output logic [3:0]             flags     // stored Z C N V
);

    localparam int MSB = `CPU_DATA_W - 1;

    logic [`CPU_DATA_W:0]   wide;   // result with carry/borrow on top
    logic                   cin;    // stored carry
    logic                   c_next;
    logic                   v_next;
    logic [3:0]             flags_next;

    assign cin = flags[cpu_pkg::FLAG_C];

    always_comb begin
        wide   = '0;
        c_next = 1'b0;
        v_next = 1'b0;
        case (op)
            cpu_pkg::ALU_ADD: begin
                wide   = {1'b0, x} + {1'b0, y};
                c_next = wide[`CPU_DATA_W];
                v_next = (x[MSB] == y[MSB]) && (wide[MSB] != x[MSB]);
            end
            cpu_pkg::ALU_ADC: begin
                wide   = {1'b0, x} + {1'b0, y} + {{`CPU_DATA_W{1'b0}}, cin};
                c_next = wide[`CPU_DATA_W];
                v_next = (x[MSB] == y[MSB]) && (wide[MSB] != x[MSB]);
            end
            cpu_pkg::ALU_SUB: begin
                wide   = {1'b0, x} - {1'b0, y};
                c_next = wide[`CPU_DATA_W]; // borrow
                v_next = (x[MSB] != y[MSB]) && (wide[MSB] != x[MSB]);
            end
            cpu_pkg::ALU_SBC: begin
                wide   = {1'b0, x} - {1'b0, y} - {{`CPU_DATA_W{1'b0}}, cin};
                c_next = wide[`CPU_DATA_W];
                v_next = (x[MSB] != y[MSB]) && (wide[MSB] != x[MSB]);
            end
            cpu_pkg::ALU_AND: wide = {1'b0, x & y};
            cpu_pkg::ALU_OR:  wide = {1'b0, x | y};
            cpu_pkg::ALU_XOR: wide = {1'b0, x ^ y};
            cpu_pkg::ALU_NOT: wide = {1'b0, ~x};
            cpu_pkg::ALU_SHL: begin
                wide   = {1'b0, x[MSB-1:0], 1'b0};
                c_next = x[MSB]; // bit shifted out
            end
            cpu_pkg::ALU_SHR: begin
                wide   = {2'b00, x[MSB:1]};
                c_next = x[0];
            end
            cpu_pkg::ALU_ROL: begin
                wide   = {1'b0, x[MSB-1:0], cin};
                c_next = x[MSB];
            end
            cpu_pkg::ALU_ROR: begin
                wide   = {1'b0, cin, x[MSB:1]};
                c_next = x[0];
            end
            cpu_pkg::ALU_MOV: wide = {1'b0, y};
            cpu_pkg::ALU_INC: begin
                wide   = {1'b0, x} + 1'b1;
                c_next = wide[`CPU_DATA_W];
            end
            cpu_pkg::ALU_DEC: begin
                wide   = {1'b0, x} - 1'b1;
                c_next = wide[`CPU_DATA_W]; // borrow from 0
            end
            default: wide = {1'b0, x}; // pass
        endcase
    end

    assign result = wide[MSB:0];

    always_comb begin
        flags_next                  = '0;
        flags_next[cpu_pkg::FLAG_Z] = result == '0;
        flags_next[cpu_pkg::FLAG_C] = c_next;
        flags_next[cpu_pkg::FLAG_N] = result[MSB];
        flags_next[cpu_pkg::FLAG_V] = v_next;
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            flags <= '0;
        end else if (we_flags) begin
            flags <= flags_next; // end of alu execute cycle
        end
    end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   n_rst,
    input  logic                   we_a,
    input  logic                   we_b,
    input  logic                   wb_from_mem,
    input  cpu_pkg::reg_idx_e      reg_sel,
    input  logic                   st_src,
    input  logic [`CPU_DATA_W-1:0] alu_result,
    input  logic [`CPU_DATA_W-1:0] mem_rdata,
    input  logic [`CPU_DATA_W-1:0] pl,          // DP low byte
    input  logic [`CPU_DATA_W-1:0] ph,          // DP high byte
    output logic [`CPU_DATA_W-1:0] a,
    output logic [`CPU_DATA_W-1:0] y_operand,
    output logic [`CPU_DATA_W-1:0] wb_data,     // also feeds PL/PH
    output logic [`CPU_DATA_W-1:0] st_data
);

    logic [`CPU_DATA_W-1:0] b;

    // ld/ldi take the bus, everything else the alu
    assign wb_data = wb_from_mem ? mem_rdata : alu_result;

    always_comb begin
        case (reg_sel)
            cpu_pkg::REG_A:  y_operand = a;
            cpu_pkg::REG_B:  y_operand = b;
            cpu_pkg::REG_PL: y_operand = pl;
            default:         y_operand = ph;
        endcase
    end

    assign st_data = st_src ? b : a;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            a <= '0;
            b <= '0;
        end else begin
            if (we_a) begin
                a <= wb_data;
            end
            if (we_b) begin
                b <= wb_data;
            end
        end
    end

endmodule

// ==== logic/pointer_unit.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module pointer_unit (
    input  logic                   clk,
    input  logic                   n_rst,
    input  logic [`CPU_DATA_W-1:0] wb_data,
    input  logic                   we_pl,
    input  logic                   we_ph,
    input  logic                   ip_inc,
    input  logic                   swap_p,   // taken jump
    input  logic                   addr_dp,
    output logic [`CPU_ADDR_W-1:0] mem_addr,
    output logic [`CPU_DATA_W-1:0] pl,
    output logic [`CPU_DATA_W-1:0] ph
);

    logic [`CPU_ADDR_W-1:0] ip;
    logic [`CPU_ADDR_W-1:0] dp; // {PH, PL}

    assign mem_addr = addr_dp ? dp : ip;
    assign pl       = dp[`CPU_DATA_W-1:0];
    assign ph       = dp[`CPU_ADDR_W-1:`CPU_DATA_W];

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            ip <= `CPU_RESET_IP;
            dp <= `CPU_RESET_IP;
        end else if (swap_p) begin
            // jump target sits in DP, old IP becomes the return pointer
            ip <= dp;
            dp <= ip;
        end else begin
            if (ip_inc) begin
                ip <= ip + 1'b1;
            end
            if (we_pl) begin
                dp[`CPU_DATA_W-1:0] <= wb_data;
            end
            if (we_ph) begin
                dp[`CPU_ADDR_W-1:`CPU_DATA_W] <= wb_data;
            end
        end
    end

endmodule

// ==== logic/cpu_top.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_top (
    input  logic                   clk,
    input  logic                   n_rst,
    input  logic [`CPU_DATA_W-1:0] mem_rdata, // combinational read
    output logic [`CPU_ADDR_W-1:0] mem_addr,
    output logic [`CPU_DATA_W-1:0] mem_wdata,
    output logic                   mem_we,
    output logic                   mem_oe,
    output logic                   halted
);

    // decode strobes
    cpu_pkg::alu_op_e  alu_op;
    cpu_pkg::reg_idx_e reg_sel;
    logic              we_a;
    logic              we_b;
    logic              we_pl;
    logic              we_ph;
    logic              we_flags;
    logic              wb_from_mem;
    logic              st_src;
    logic              addr_dp;
    logic              ip_inc;
    logic              swap_p;

    // datapath
    logic [3:0]             flags;
    logic [`CPU_DATA_W-1:0] alu_result;
    logic [`CPU_DATA_W-1:0] a;
    logic [`CPU_DATA_W-1:0] y_operand;
    logic [`CPU_DATA_W-1:0] wb_data;
    logic [`CPU_DATA_W-1:0] pl;
    logic [`CPU_DATA_W-1:0] ph;

    control_unit u_ctrl (
        .clk         (clk),
        .n_rst       (n_rst),
        .mem_rdata   (mem_rdata),
        .flags       (flags),
        .alu_op      (alu_op),
        .reg_sel     (reg_sel),
        .we_a        (we_a),
        .we_b        (we_b),
        .we_pl       (we_pl),
        .we_ph       (we_ph),
        .we_flags    (we_flags),
        .wb_from_mem (wb_from_mem),
        .st_src      (st_src),
        .addr_dp     (addr_dp),
        .ip_inc      (ip_inc),
        .swap_p      (swap_p),
        .mem_we      (mem_we),
        .mem_oe      (mem_oe),
        .halted      (halted)
    );

    alu u_alu (
        .clk      (clk),
        .n_rst    (n_rst),
        .x        (a),
        .y        (y_operand),
        .op       (alu_op),
        .we_flags (we_flags),
        .result   (alu_result),
        .flags    (flags)
    );

    reg_file u_regs (
        .clk         (clk),
        .n_rst       (n_rst),
        .we_a        (we_a),
        .we_b        (we_b),
        .wb_from_mem (wb_from_mem),
        .reg_sel     (reg_sel),
        .st_src      (st_src),
        .alu_result  (alu_result),
        .mem_rdata   (mem_rdata),
        .pl          (pl),
        .ph          (ph),
        .a           (a),
        .y_operand   (y_operand),
        .wb_data     (wb_data),
        .st_data     (mem_wdata) // store byte straight to the bus
    );

    pointer_unit u_ptr (
        .clk      (clk),
        .n_rst    (n_rst),
        .wb_data  (wb_data),
        .we_pl    (we_pl),
        .we_ph    (we_ph),
        .ip_inc   (ip_inc),
        .swap_p   (swap_p),
        .addr_dp  (addr_dp),
        .mem_addr (mem_addr),
        .pl       (pl),
        .ph       (ph)
    );

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter realtime HALF_PERIOD = 4.0 // 8 ns clock
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

endmodule

// ==== dv/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;

    logic        clk;
    logic        n_rst;
    logic [7:0]  mem_rdata;
    logic [15:0] mem_addr;
    logic [7:0]  mem_wdata;
    logic        mem_we;
    logic        mem_oe;
    logic        halted;
    logic        copy_req; // loads the model from the reference image

    logic [7:0]  mem [0:65535];  // memory seen by the dut
    logic [7:0]  rmem [0:65535]; // reference image, also program builder target

    // architectural state of the reference model
    logic [15:0] r_ip;
    logic [15:0] r_dp; // {PH, PL}
    logic [7:0]  r_a;
    logic [7:0]  r_b;
    logic [3:0]  r_f;  // V N C Z
    logic        r_halt;

    logic [31:0] rng;
    logic [15:0] pc; // builder write pointer

    tb_clock_gen u_clk (.clk(clk));

    cpu_top dut (
        .clk       (clk),
        .n_rst     (n_rst),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_oe    (mem_oe),
        .halted    (halted)
    );

    assign mem_rdata = mem[mem_addr]; // combinational read

    always @(posedge clk) begin
        if (copy_req) begin
            for (int i = 0; i < 65536; i++) begin
                mem[i] <= rmem[i];
            end
        end else if (mem_we) begin
            mem[mem_addr] <= mem_wdata; // single-cycle write
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %0h actual %0h", name, exp, act);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "stopped on failure");
    endtask

    // alu result and flags straight from the flag rules
    function automatic void alu_ref(input logic [3:0] op, input logic [7:0] x,
                                    input logic [7:0] y, input logic cin,
                                    output logic [7:0] res, output logic [3:0] f);
        int   sum; // signed result for overflow
        logic c;
        logic v;
        c   = 1'b0;
        v   = 1'b0;
        sum = 0;
        case (op)
            4'd0: begin
                res = x + y;
                c   = (int'(x) + int'(y)) > 255;
                sum = int'($signed(x)) + int'($signed(y));
            end
            4'd1: begin
                res = x + y + {7'd0, cin};
                c   = (int'(x) + int'(y) + int'(cin)) > 255;
                sum = int'($signed(x)) + int'($signed(y)) + int'(cin);
            end
            4'd2: begin
                res = x - y;
                c   = x < y; // borrow
                sum = int'($signed(x)) - int'($signed(y));
            end
            4'd3: begin
                res = x - y - {7'd0, cin};
                c   = int'(x) < (int'(y) + int'(cin));
                sum = int'($signed(x)) - int'($signed(y)) - int'(cin);
            end
            4'd4: res = x & y;
            4'd5: res = x | y;
            4'd6: res = x ^ y;
            4'd7: res = ~x;
            4'd8: begin
                res = {x[6:0], 1'b0};
                c   = x[7];
            end
            4'd9: begin
                res = {1'b0, x[7:1]};
                c   = x[0];
            end
            4'd10: begin
                res = {x[6:0], cin}; // rotate through carry
                c   = x[7];
            end
            4'd11: begin
                res = {cin, x[7:1]};
                c   = x[0];
            end
            4'd12: res = y;
            4'd13: begin
                res = x + 8'd1;
                c   = x == 8'hFF;
            end
            4'd14: begin
                res = x - 8'd1;
                c   = x == 8'h00;
            end
            default: res = x;
        endcase
        if (op < 4'd4) begin
            v = (sum > 127) || (sum < -128);
        end
        f = {v, res[7], c, res == 8'h00};
    endfunction

    function automatic logic [7:0] get_reg(input logic [1:0] dd);
        case (dd)
            2'd0: return r_a;
            2'd1: return r_b;
            2'd2: return r_dp[7:0];
            default: return r_dp[15:8];
        endcase
    endfunction

    function automatic void set_reg(input logic [1:0] dd, input logic [7:0] val);
        case (dd)
            2'd0: r_a = val;
            2'd1: r_b = val;
            2'd2: r_dp[7:0] = val;
            default: r_dp[15:8] = val;
        endcase
    endfunction

    // one instruction on the reference state
    function automatic void ref_step(output logic [15:0] fetch_addr, output logic exp_we,
                                     output logic addr_chk, output logic [15:0] exp_addr,
                                     output logic [7:0] exp_data);
        logic [7:0]  ir;
        logic [7:0]  res;
        logic [3:0]  f;
        logic [15:0] t;
        fetch_addr = r_ip;
        ir         = rmem[r_ip];
        r_ip       = r_ip + 16'd1;
        exp_we     = 1'b0;
        addr_chk   = 1'b0;
        exp_addr   = '0;
        exp_data   = '0;
        if (!ir[7]) begin
            alu_ref(ir[6:3], r_a, get_reg(ir[1:0]), r_f[1], res, f);
            r_f = f;
            set_reg(ir[2] ? ir[1:0] : 2'd0, res); // alu0 always targets A
        end else if (ir[7:4] == 4'b1000) begin
            addr_chk = 1'b1;
            exp_addr = r_dp;
            set_reg(ir[1:0], rmem[r_dp]);
        end else if (ir[7:4] == 4'b1010) begin
            addr_chk = 1'b1;
            exp_addr = r_ip; // immediate byte
            set_reg(ir[1:0], rmem[r_ip]);
            r_ip = r_ip + 16'd1;
        end else if (ir[7:4] == 4'b1011) begin
            exp_we   = 1'b1;
            addr_chk = 1'b1;
            exp_addr = r_dp;
            exp_data = ir[0] ? r_b : r_a;
            rmem[r_dp] = exp_data;
        end else if ((ir[7:3] == 5'b11000 && (r_f[ir[1:0]] ^ ir[2])) || ir[7:3] == 5'b11001) begin
            t    = r_ip; // taken jump exchanges pointers
            r_ip = r_dp;
            r_dp = t;
        end else if (ir == 8'hFF) begin
            r_halt = 1'b1;
        end
    endfunction

    function automatic void emit(input logic [7:0] b);
        rmem[pc] = b;
        pc       = pc + 16'd1;
    endfunction

    function automatic void clear_image();
        for (int i = 0; i < 65536; i++) begin
            rmem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'hA5; // whole-address filler
        end
        pc = '0;
    endfunction

    task automatic reset_dut();
        @(posedge clk);
        n_rst    <= 1'b0;
        copy_req <= 1'b1;
        @(posedge clk);
        copy_req <= 1'b0;
        repeat (7) @(posedge clk);
        check("reset mem_we", 32'(1'b0), 32'(mem_we));
        check("reset halted", 32'(1'b0), 32'(halted));
        r_ip   = 16'h0000;
        r_dp   = 16'h0000;
        r_a    = '0;
        r_b    = '0;
        r_f    = '0;
        r_halt = 1'b0;
        n_rst <= 1'b1; // first fetch in the next cycle
    endtask

    task automatic wait_halted(input string name);
        int t;
        t = 0;
        while (!halted && t < 4) begin
            @(negedge clk);
            t++;
        end
        if (!halted) begin
            fail_now({name, ": timeout waiting for halted after HLT"});
        end
    endtask

    // lockstep compare against ref_step, sampled at the falling edge
    task automatic run_program(input string name, input int max_instr);
        logic [15:0] fa;
        logic        ewe;
        logic        achk;
        logic [15:0] eaddr;
        logic [7:0]  edata;
        logic [15:0] hold_addr;
        reset_dut();
        for (int k = 0; k < max_instr && !r_halt; k++) begin
            @(negedge clk); // fetch
            ref_step(fa, ewe, achk, eaddr, edata);
            check({name, " fetch addr"}, 32'(fa), 32'(mem_addr));
            check({name, " fetch oe"}, 32'(1'b1), 32'(mem_oe));
            check({name, " fetch we"}, 32'(1'b0), 32'(mem_we));
            @(negedge clk); // execute
            check({name, " exec we"}, 32'(ewe), 32'(mem_we));
            if (achk) begin
                check({name, " exec addr"}, 32'(eaddr), 32'(mem_addr));
            end
            if (ewe) begin
                check({name, " store data"}, 32'(edata), 32'(mem_wdata));
            end
        end
        if (r_halt) begin
            wait_halted(name);
            hold_addr = mem_addr;
            check({name, " halt addr"}, 32'(r_ip), 32'(hold_addr));
            repeat (50) begin
                @(negedge clk);
                check({name, " halted"}, 32'(1'b1), 32'(halted));
                check({name, " halt oe"}, 32'(1'b0), 32'(mem_oe));
                check({name, " halt we"}, 32'(1'b0), 32'(mem_we));
                check({name, " halt addr held"}, 32'(hold_addr), 32'(mem_addr));
            end
        end
    endtask

    initial begin
        logic [15:0] target;
        logic [7:0]  vals [4];
        n_rst     = 1'b0;
        copy_req  = 1'b0;
        rng       = 32'h16bd_1455;
        vals      = '{8'h80, 8'h40, 8'hC0, 8'h00}; // Z/C/V, N/V, C/N, Z via A+A

        // reset, LDI then HLT
        clear_image();
        emit(8'hA0);
        emit(8'h3C);
        emit(8'hFF);
        run_program("reset", 10);

        // every alu op in both forms, stores walk through DP
        clear_image();
        emit(8'hA3);
        emit(8'h80); // PH = 80
        for (int op = 0; op < 16; op++) begin
            emit(8'hA0);
            emit(8'(next_rand()));
            emit(8'hA1);
            emit(8'(next_rand()));
            emit({1'b0, 4'(op), 3'b001}); // alu0 A, B
            emit(8'hB0);                 // st A
            emit(8'hA0);
            emit(8'(next_rand()));
            emit({1'b0, 4'(op), 3'b101}); // alu1 B
            emit(8'hB1);                 // st B
            emit(8'h6E);                 // PL = A + 1 for the next stores
        end
        emit(8'hFF);
        run_program("alu", 400);

        // LD/ST through DP
        clear_image();
        rmem[16'h1234] = 8'(next_rand());
        rmem[16'h1235] = 8'(next_rand());
        rmem[16'hC035] = 8'h77;
        emit(8'hA2);
        emit(8'h34);
        emit(8'hA3);
        emit(8'h12);
        emit(8'h80); // ld A from 1234
        emit(8'hB0); // st A back to 1234
        emit(8'h62); // A = PL
        emit(8'h6E); // PL = A + 1
        emit(8'h81); // ld B from 1235
        emit(8'hB1);
        emit(8'hA3);
        emit(8'hC0);
        emit(8'h82); // ld PL from C035
        emit(8'hB0);
        emit(8'hFF);
        run_program("pointer", 50);

        // Jc on each flag and polarity, then JMP
        clear_image();
        for (int ff = 0; ff < 4; ff++) begin
            for (int i = 0; i < 2; i++) begin
                foreach (vals[v]) begin
                    target = pc + 16'd9; // skips the nop when taken
                    emit(8'hA0);
                    emit(vals[v]);
                    emit(8'h00); // add A, A sets flags
                    emit(8'hA2);
                    emit(target[7:0]);
                    emit(8'hA3);
                    emit(target[15:8]);
                    emit({5'b11000, 1'(i), 2'(ff)});
                    emit(8'hD0);
                end
            end
        end
        target = pc + 16'd6;
        emit(8'hA2);
        emit(target[7:0]);
        emit(8'hA3);
        emit(target[15:8]);
        emit(8'hC8);
        emit(8'hD0);
        emit(8'hFF);
        run_program("jump", 400);

        // random image, HLT bytes replaced by a nop
        for (int i = 0; i < 65536; i++) begin
            rmem[i] = 8'(next_rand());
            if (rmem[i] == 8'hFF) begin
                rmem[i] = 8'hFE;
            end
        end
        run_program("random", 1500); // 3000 cycles

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== cpu_top.f ====
+incdir+logic
logic/cpu_pkg.sv
logic/control_unit.sv
logic/alu.sv
logic/reg_file.sv
logic/pointer_unit.sv
logic/cpu_top.sv
dv/tb_clock_gen.sv
dv/cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := cpu_tb
FILELIST  := cpu_top.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
